// File: hw/xbar_macros.svh
// Stream switch sizes

`ifndef XBAR_MACROS_SVH
`define XBAR_MACROS_SVH

// ========================================
// switch geometry
// ========================================

`define XBAR_PORTS  4                  // inputs and outputs of the crosspoint
`define XBAR_SEL_W  2                  // width of an input or output index

// ========================================
// datapath and statistics widths
// ========================================

`define XBAR_DATA_W 64                 // tdata bits per beat
`define XBAR_KEEP_W 8                  // one tkeep bit per data byte
`define XBAR_CNT_W  16                 // beat and frame counters, also the response data

`endif

// File: hw/xbar_pkg.sv
// Stream switch types

`include "xbar_macros.svh"

package xbar_pkg;

    // ========================================
    // stream beat
    // ========================================

    typedef struct packed {
        logic                    valid;    // beat present this cycle
        logic [`XBAR_DATA_W-1:0] data;
        logic [`XBAR_KEEP_W-1:0] keep;
        logic                    last;     // final beat of a frame
        logic                    user;
    } axis_beat_t;

    // ========================================
    // control port
    // ========================================

    typedef enum logic [2:0] {
        OP_SET_ROUTE   = 3'd0,             // route[port] = value
        OP_GET_ROUTE   = 3'd1,
        OP_GET_BEATS   = 3'd2,
        OP_GET_FRAMES  = 3'd3,
        OP_CLEAR_STATS = 3'd4              // codes 5 to 7 are undefined
    } ctrl_op_e;

    typedef struct packed {
        ctrl_op_e               op;
        logic [`XBAR_SEL_W-1:0] port;      // output index
        logic [`XBAR_SEL_W-1:0] value;     // input index, only for OP_SET_ROUTE
    } ctrl_cmd_t;

    typedef struct packed {
        logic [`XBAR_CNT_W-1:0] data;
        logic                   error;     // undefined opcode
    } ctrl_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,                           // waiting for a request
        ST_EXEC,                           // command takes effect
        ST_ACK,                            // response settled, raise ack
        ST_WAIT_DROP                       // ack held until the request falls
    } route_state_e;

    // one input index per output, output 0 in the low bits
    typedef struct packed {
        logic [`XBAR_PORTS-1:0][`XBAR_SEL_W-1:0] sel;
    } route_map_t;

endpackage

// File: hw/route_ctrl.sv
// Control port decoder and route table

`timescale 1ns/100ps

`include "xbar_macros.svh"

module route_ctrl (
    input  logic                   clk,
    input  logic                   rst,

    // four-phase control port
    input  logic                   ctrl_req,
    input  xbar_pkg::ctrl_cmd_t    ctrl_cmd,
    output logic                   ctrl_ack,
    output xbar_pkg::ctrl_rsp_t    ctrl_rsp,

    // to the crosspoint
    output xbar_pkg::route_map_t   routes,

    // to and from the statistics block
    output logic                   stats_clear,
    output logic [`XBAR_SEL_W-1:0] stats_port,
    input  logic [`XBAR_CNT_W-1:0] beat_count,
    input  logic [`XBAR_CNT_W-1:0] frame_count
);

    xbar_pkg::route_state_e state;
    xbar_pkg::ctrl_cmd_t    cmd_q;         // command held for the whole transaction

    // ========================================
    // handshake FSM and command execution
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= xbar_pkg::ST_IDLE;
            cmd_q    <= '0;
            ctrl_ack <= 1'b0;
            ctrl_rsp <= '0;
            routes   <= '0;                // every output starts on input 0
        end else begin
            case (state)
                xbar_pkg::ST_IDLE: begin
                    if (ctrl_req) begin
                        cmd_q <= ctrl_cmd; // master keeps the command stable under req
                        state <= xbar_pkg::ST_EXEC;
                    end
                end

                xbar_pkg::ST_EXEC: begin
                    ctrl_rsp.error <= 1'b0;
                    case (cmd_q.op)
                        xbar_pkg::OP_SET_ROUTE: begin
                            routes.sel[cmd_q.port] <= cmd_q.value;
                            ctrl_rsp.data          <= '0;
                        end
                        xbar_pkg::OP_GET_ROUTE: begin
                            ctrl_rsp.data <= {{(`XBAR_CNT_W-`XBAR_SEL_W){1'b0}},
                                              routes.sel[cmd_q.port]};
                        end
                        xbar_pkg::OP_GET_BEATS: begin
                            ctrl_rsp.data <= beat_count;   // stats_port already steered
                        end
                        xbar_pkg::OP_GET_FRAMES: begin
                            ctrl_rsp.data <= frame_count;
                        end
                        xbar_pkg::OP_CLEAR_STATS: begin
                            ctrl_rsp.data <= '0;           // stats_clear is high this cycle
                        end
                        default: begin
                            ctrl_rsp.data  <= '0;
                            ctrl_rsp.error <= 1'b1;        // route table left untouched
                        end
                    endcase
                    state <= xbar_pkg::ST_ACK;
                end

                xbar_pkg::ST_ACK: begin
                    ctrl_ack <= 1'b1;      // response is stable from here on
                    state    <= xbar_pkg::ST_WAIT_DROP;
                end

                xbar_pkg::ST_WAIT_DROP: begin
                    if (!ctrl_req) begin
                        ctrl_ack <= 1'b0;
                        state    <= xbar_pkg::ST_IDLE;
                    end
                end

                default: begin
                    state <= xbar_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // the statistics read mux follows the held command, so a count read in
    // ST_EXEC sees the counters as they stood one cycle after the request
    assign stats_port  = cmd_q.port;
    assign stats_clear = (state == xbar_pkg::ST_EXEC) &&
                         (cmd_q.op == xbar_pkg::OP_CLEAR_STATS);

    // ========================================
    // protocol checks
    // ========================================

    // ack may only rise while the master is still requesting
    assert property (@(posedge clk) disable iff (rst)
        $rose(ctrl_ack) |-> ctrl_req)
        else $error("ctrl_ack rose without ctrl_req");

    // a clear lasts exactly one cycle per command
    assert property (@(posedge clk) disable iff (rst)
        stats_clear |=> !stats_clear)
        else $error("stats_clear held for more than one cycle");

endmodule

// File: hw/axis_crosspoint.sv
// Registered 4x4 stream crosspoint

`timescale 1ns/100ps

`include "xbar_macros.svh"

module axis_crosspoint (
    input  logic                                     clk,
    input  logic                                     rst,

    input  xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0]   in_beats,
    input  xbar_pkg::route_map_t                     routes,

    output xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0]   out_beats
);

    // ========================================
    // pipeline registers
    // ========================================

    xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] in_q;    // stage 1 holds one beat per input
    xbar_pkg::route_map_t                   route_q; // stage 1 route map that steers the mux
    xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] out_q;   // stage 2 holds one beat per output

    // Stage 1 captures every input beat together with the route map. Stage 2
    // loads each output from the captured beat its captured route points to.
    // Both stages see the same route, so a route change never splits a beat
    // across two inputs.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `XBAR_PORTS; i++) begin
            in_q[i]  <= in_beats[i];
            out_q[i] <= in_q[route_q.sel[i]];        // several outputs may share one input
        end

        if (rst) begin
            route_q <= '0;
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                in_q[i].valid  <= 1'b0;              // payload fields keep their value
                out_q[i].valid <= 1'b0;
            end
        end else begin
            route_q <= routes;
        end
    end

    assign out_beats = out_q;

    // ========================================
    // checks
    // ========================================

    // the first output after reset comes from the emptied input stage
    for (genvar g = 0; g < `XBAR_PORTS; g++) begin : g_rst_chk
        assert property (@(posedge clk) $fell(rst) |=> !out_q[g].valid)
            else $error("output %0d valid after reset", g);
    end

endmodule

// File: hw/stream_stats.sv
// Per-output beat and frame counters

`timescale 1ns/100ps

`include "xbar_macros.svh"

module stream_stats (
    input  logic                                   clk,
    input  logic                                   rst,

    input  xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] out_beats,  // observed, not driven

    input  logic                                   stats_clear,
    input  logic [`XBAR_SEL_W-1:0]                 stats_port,
    output logic [`XBAR_CNT_W-1:0]                 beat_count,
    output logic [`XBAR_CNT_W-1:0]                 frame_count
);

    logic [`XBAR_CNT_W-1:0] beat_cnt  [`XBAR_PORTS];  // valid beats per output
    logic [`XBAR_CNT_W-1:0] frame_cnt [`XBAR_PORTS];  // valid beats with last

    // ========================================
    // saturating increment
    // ========================================

    function automatic logic [`XBAR_CNT_W-1:0] sat_inc(
        input logic [`XBAR_CNT_W-1:0] cnt,
        input logic                   hit
    );
        if (hit && (cnt != '1)) begin
            return cnt + 1'b1;
        end else begin
            return cnt;                    // idle cycle, or already pinned at all ones
        end
    endfunction

    // ========================================
    // counters
    // ========================================

    always_ff @(posedge clk) begin
        if (rst || stats_clear) begin
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                beat_cnt[i]  <= '0;
                frame_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                beat_cnt[i]  <= sat_inc(beat_cnt[i], out_beats[i].valid);
                frame_cnt[i] <= sat_inc(frame_cnt[i],
                                        out_beats[i].valid && out_beats[i].last);
            end
        end
    end

    // read mux, combinational so the decoder can latch it in one cycle
    assign beat_count  = beat_cnt[stats_port];
    assign frame_count = frame_cnt[stats_port];

endmodule

// File: hw/xbar_top.sv
// Stream switch top level

`timescale 1ns/100ps

`include "xbar_macros.svh"

module xbar_top (
    input  logic                                   clk,
    input  logic                                   rst,

    // stream side
    input  xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] in_beats,
    output xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] out_beats,

    // control side
    input  logic                                   ctrl_req,
    input  xbar_pkg::ctrl_cmd_t                    ctrl_cmd,
    output logic                                   ctrl_ack,
    output xbar_pkg::ctrl_rsp_t                    ctrl_rsp
);

    xbar_pkg::route_map_t   routes;
    logic                   stats_clear;
    logic [`XBAR_SEL_W-1:0] stats_port;
    logic [`XBAR_CNT_W-1:0] beat_count;
    logic [`XBAR_CNT_W-1:0] frame_count;

    route_ctrl u_route_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ctrl_req    (ctrl_req),
        .ctrl_cmd    (ctrl_cmd),
        .ctrl_ack    (ctrl_ack),
        .ctrl_rsp    (ctrl_rsp),
        .routes      (routes),
        .stats_clear (stats_clear),
        .stats_port  (stats_port),
        .beat_count  (beat_count),
        .frame_count (frame_count)
    );

    axis_crosspoint u_crosspoint (
        .clk       (clk),
        .rst       (rst),
        .in_beats  (in_beats),
        .routes    (routes),
        .out_beats (out_beats)
    );

    // counts what actually leaves the switch
    stream_stats u_stats (
        .clk         (clk),
        .rst         (rst),
        .out_beats   (out_beats),
        .stats_clear (stats_clear),
        .stats_port  (stats_port),
        .beat_count  (beat_count),
        .frame_count (frame_count)
    );

endmodule

// File: bench/xbar_tb.sv
// Stream switch testbench

`timescale 1ns/100ps

`include "xbar_macros.svh"

module xbar_tb;

    localparam int ACK_TIMEOUT = 50;       // cycles allowed for each handshake phase

    logic                                   clk;
    logic                                   rst;
    xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] in_beats;
    xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] out_beats;
    logic                                   ctrl_req;
    xbar_pkg::ctrl_cmd_t                    ctrl_cmd;
    logic                                   ctrl_ack;
    xbar_pkg::ctrl_rsp_t                    ctrl_rsp;

    integer                                  seed;
    string                                   test_name;
    logic [`XBAR_PORTS-1:0][`XBAR_SEL_W-1:0] route_copy;  // routes as the testbench wrote them
    int                                      exp_beats   [`XBAR_PORTS];
    int                                      exp_frames  [`XBAR_PORTS];
    int                                      base_beats  [`XBAR_PORTS];  // totals at last clear
    int                                      base_frames [`XBAR_PORTS];

    xbar_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_beats  (in_beats),
        .out_beats (out_beats),
        .ctrl_req  (ctrl_req),
        .ctrl_cmd  (ctrl_cmd),
        .ctrl_ack  (ctrl_ack),
        .ctrl_rsp  (ctrl_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // helpers
    // ========================================

    task automatic check_equal(input string name, input logic [79:0] expected,
                               input logic [79:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("Errors found");
        $fatal(1, "control handshake stalled");
    endtask

    // an output carries the beat of the input its route selects
    function automatic xbar_pkg::axis_beat_t predict_beat(
        input xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0] beats,
        input logic [`XBAR_SEL_W-1:0]                 sel
    );
        xbar_pkg::axis_beat_t b;
        b = beats[sel];
        if (!b.valid) begin
            b = '0;                        // payload of an empty cycle is not compared
        end
        return b;
    endfunction

    function automatic xbar_pkg::axis_beat_t random_beat(input bit dense);
        xbar_pkg::axis_beat_t b;
        logic [31:0]          r;
        r       = $random(seed);
        b.data  = {$random(seed), $random(seed)};
        b.keep  = r[7:0];
        b.last  = r[8];
        b.user  = r[9];
        b.valid = dense | r[16] | r[17];   // sparse traffic is about three quarters full
        return b;
    endfunction

    task automatic ctrl_transact(input logic [2:0] op, input logic [1:0] port,
                                 input logic [1:0] value, output xbar_pkg::ctrl_rsp_t rsp);
        int cycles;
        @(posedge clk);
        ctrl_cmd <= {op, port, value};
        ctrl_req <= 1'b1;
        cycles = 0;
        while (!ctrl_ack) begin
            @(posedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                report_timeout("ctrl_ack did not rise after ctrl_req was raised");
            end
        end
        rsp = ctrl_rsp;
        ctrl_req <= 1'b0;
        if (op == xbar_pkg::OP_SET_ROUTE && !rsp.error) begin
            route_copy[port] <= value;
        end
        cycles = 0;
        while (ctrl_ack) begin
            @(posedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                report_timeout("ctrl_ack stayed high after ctrl_req was lowered");
            end
        end
    endtask

    task automatic write_route(input int port, input int sel);
        xbar_pkg::ctrl_rsp_t rsp;
        ctrl_transact(xbar_pkg::OP_SET_ROUTE, 2'(port), 2'(sel), rsp);
        check_equal($sformatf("%s set route %0d", test_name, port), 80'({16'd0, 1'b0}),
                    80'(rsp));
    endtask

    task automatic read_route(input int port, input int expected);
        xbar_pkg::ctrl_rsp_t rsp;
        ctrl_transact(xbar_pkg::OP_GET_ROUTE, 2'(port), 2'd0, rsp);
        check_equal($sformatf("%s route %0d", test_name, port),
                    80'({16'(expected), 1'b0}), 80'(rsp));
    endtask

    task automatic read_counts(input int port);
        xbar_pkg::ctrl_rsp_t rsp;
        ctrl_transact(xbar_pkg::OP_GET_BEATS, 2'(port), 2'd0, rsp);
        check_equal($sformatf("%s beats %0d", test_name, port),
                    80'({16'(exp_beats[port] - base_beats[port]), 1'b0}), 80'(rsp));
        ctrl_transact(xbar_pkg::OP_GET_FRAMES, 2'(port), 2'd0, rsp);
        check_equal($sformatf("%s frames %0d", test_name, port),
                    80'({16'(exp_frames[port] - base_frames[port]), 1'b0}), 80'(rsp));
    endtask

    task automatic stream_random(input int n, input bit dense);
        repeat (n) begin
            @(posedge clk);
            for (int i = 0; i < `XBAR_PORTS; i++) begin
                in_beats[i] <= random_beat(dense);
            end
        end
        @(posedge clk);
        in_beats <= '0;
        repeat (4) @(posedge clk);         // lets the pipeline and counters drain
    endtask

    // ========================================
    // output compare
    // ========================================

    initial begin : compare_outputs
        xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0]  in_d1;
        xbar_pkg::axis_beat_t [`XBAR_PORTS-1:0]  in_d2;
        logic [`XBAR_PORTS-1:0][`XBAR_SEL_W-1:0] rt_d1;
        logic [`XBAR_PORTS-1:0][`XBAR_SEL_W-1:0] rt_d2;
        xbar_pkg::axis_beat_t                    exp_b;
        in_d1 = '0;
        in_d2 = '0;
        rt_d1 = '0;
        rt_d2 = '0;
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            exp_beats[o]  = 0;
            exp_frames[o] = 0;
        end
        forever begin
            @(posedge clk);
            if (rst) begin
                in_d1 = '0;
                in_d2 = '0;
            end else begin
                for (int o = 0; o < `XBAR_PORTS; o++) begin
                    exp_b = predict_beat(in_d2, rt_d2[o]);
                    if (exp_b.valid) begin
                        check_equal($sformatf("%s out %0d beat", test_name, o),
                                    80'(exp_b), 80'(out_beats[o]));
                        exp_beats[o]++;
                        if (exp_b.last) begin
                            exp_frames[o]++;
                        end
                    end else begin
                        check_equal($sformatf("%s out %0d valid", test_name, o),
                                    80'(1'b0), 80'(out_beats[o].valid));
                    end
                end
                in_d2 = in_d1;             // beat and route from two edges back
                rt_d2 = rt_d1;
                in_d1 = in_beats;
                rt_d1 = route_copy;
            end
        end
    end

    // ========================================
    // tests
    // ========================================

    initial begin : run_tests
        xbar_pkg::ctrl_rsp_t rsp;
        seed       = 32'hb183ad9e;
        rst        = 1'b1;
        ctrl_req   = 1'b0;
        ctrl_cmd   = '0;
        in_beats   = '0;
        route_copy = '0;
        test_name  = "reset";
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            base_beats[o]  = 0;
            base_frames[o] = 0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        for (int o = 0; o < `XBAR_PORTS; o++) begin
            check_equal($sformatf("reset out %0d valid", o), 80'(1'b0),
                        80'(out_beats[o].valid));
        end
        check_equal("reset ack", 80'(1'b0), 80'(ctrl_ack));
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_route(o, 0);
            read_counts(o);
        end

        test_name = "routing";
        write_route(0, 2);
        write_route(1, 0);
        write_route(2, 3);
        write_route(3, 1);
        stream_random(200, 1'b1);

        test_name = "broadcast";
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            write_route(o, 1);
        end
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_route(o, 1);
        end
        stream_random(60, 1'b1);
        test_name = "reroute";
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            write_route(o, 3 - o);
        end
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_route(o, 3 - o);
        end
        stream_random(60, 1'b0);

        test_name = "statistics";
        write_route(1, 3);                 // two outputs share input 3
        stream_random(300, 1'b0);
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_counts(o);
        end

        test_name = "clear";
        ctrl_transact(xbar_pkg::OP_CLEAR_STATS, 2'd0, 2'd0, rsp);
        check_equal("clear response", 80'({16'd0, 1'b0}), 80'(rsp));
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            base_beats[o]  = exp_beats[o];
            base_frames[o] = exp_frames[o];
        end
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_counts(o);
        end
        stream_random(40, 1'b0);
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_counts(o);
        end

        test_name = "undefined op";
        for (int op = 5; op < 8; op++) begin
            ctrl_transact(3'(op), 2'(op - 5), 2'd2, rsp);
            check_equal($sformatf("undefined op %0d", op), 80'({16'd0, 1'b1}), 80'(rsp));
        end
        for (int o = 0; o < `XBAR_PORTS; o++) begin
            read_route(o, int'(route_copy[o]));
        end
        stream_random(20, 1'b1);

        $display("No errors");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/xbar_pkg.sv
hw/route_ctrl.sv
hw/axis_crosspoint.sv
hw/stream_stats.sv
hw/xbar_top.sv
bench/xbar_tb.sv

// File: Makefile
TOP = xbar_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f tb.f

# the run passes only when the pass line shows up in the simulator output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
